// ==== include/serdes_defs.svh ====
`ifndef SERDES_DEFS_SVH
`define SERDES_DEFS_SVH

////////////////////////////////////////////////////////////
// serial link sizing

// bits per serial word, 2 to 8
`define SER_WIDTH 8

// training word periods after reset
`define TRAIN_WORDS 16

// consecutive good training words before lock
`define LOCK_COUNT 4

// deepest line delay in cycles, matches delay_t range
`define MAX_DELAY 15

`endif

// ==== rtl/serdes_pkg.sv ====
package serdes_pkg;

`include "serdes_defs.svh"

    ////////////////////////////////////////////////////////////
    // data path widths

    typedef logic [`SER_WIDTH-1:0] word_t;   // one parallel word
    typedef logic [3:0]            delay_t;  // line delay select, 0 to 15
    typedef logic [2:0]            bit_cnt_t; // bit slot inside a word period
    typedef logic [4:0]            word_cnt_t; // training words and match runs

    ////////////////////////////////////////////////////////////
    // state machines

    typedef enum logic {
        SER_TRAIN,  // fixed training word on the line
        SER_DATA    // switch word on the line
    } ser_state_t;

    typedef enum logic {
        DES_SEARCH, // hunting for the word boundary
        DES_LOCKED  // boundary found, words valid
    } des_state_t;

endpackage

// ==== rtl/word_serializer.sv ====
`timescale 1ns/1ns
`include "serdes_defs.svh"

module word_serializer import serdes_pkg::*; (
    input  logic       CLK,
    input  logic       rst,
    input  logic [7:0] sw,
    output logic       ser_bit
);

    // single one then zeros, every rotation is distinct
    localparam word_t TRAIN_WORD = {1'b1, {(`SER_WIDTH - 1){1'b0}}};

    ser_state_t state;
    word_cnt_t  train_cnt;   // training periods already sent
    bit_cnt_t   bit_cnt;
    word_t      shift_reg;
    word_t      sw_word;
    logic       last_bit;

    assign sw_word  = sw[`SER_WIDTH-1:0];   // upper switches ignored
    assign last_bit = (bit_cnt == bit_cnt_t'(`SER_WIDTH - 1));
    assign ser_bit  = shift_reg[`SER_WIDTH-1]; // msb first

    ////////////////////////////////////////////////////////////
    // word period counter

    always_ff @(posedge CLK) begin
        if (rst) begin
            bit_cnt <= '0;
        end else if (last_bit) begin
            bit_cnt <= '0;
        end else begin
            bit_cnt <= bit_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // training phase, then data forever

    always_ff @(posedge CLK) begin
        if (rst) begin
            state     <= SER_TRAIN;
            train_cnt <= '0;
        end else if (last_bit && state == SER_TRAIN) begin
            if (train_cnt == word_cnt_t'(`TRAIN_WORDS - 1)) begin
                state <= SER_DATA;
            end else begin
                train_cnt <= train_cnt + 1'b1;
            end
        end
    end

    // loaded during reset so the first training msb is out right away
    always_ff @(posedge CLK) begin
        if (rst) begin
            shift_reg <= TRAIN_WORD;
        end else if (last_bit) begin
            // sw sampled here, goes out next period
            if (state == SER_TRAIN && train_cnt != word_cnt_t'(`TRAIN_WORDS - 1)) begin
                shift_reg <= TRAIN_WORD;
            end else begin
                shift_reg <= sw_word;
            end
        end else begin
            shift_reg <= shift_reg << 1;
        end
    end

    // period length depends on the counter wrapping at the right slot
    a_bit_cnt_range: assert property (
        @(posedge CLK) disable iff (rst)
        bit_cnt < `SER_WIDTH
    ) else $error("serializer bit counter out of range");

endmodule

// ==== rtl/line_delay.sv ====
`timescale 1ns/1ns
`include "serdes_defs.svh"

module line_delay import serdes_pkg::*; (
    input  logic   CLK,
    input  logic   rst,
    input  delay_t delay_sel,
    input  logic   ser_bit,
    output logic   line_bit
);

    // stage[k] holds ser_bit from k+1 cycles ago
    logic [`MAX_DELAY-1:0] stage;

    ////////////////////////////////////////////////////////////
    // skew line

    always_ff @(posedge CLK) begin
        if (rst) begin
            stage <= '0;   // line idles low
        end else begin
            stage <= {stage[`MAX_DELAY-2:0], ser_bit};
        end
    end

    // tap 0 bypasses the registers
    always_comb begin
        if (delay_sel == '0) begin
            line_bit = ser_bit;
        end else begin
            line_bit = stage[delay_sel - 1'b1];
        end
    end

    // skew is fixed between resets
    a_delay_stable: assert property (
        @(posedge CLK) disable iff (rst)
        $stable(delay_sel)
    ) else $error("delay_sel changed outside reset");

endmodule

// ==== rtl/word_deserializer.sv ====
`timescale 1ns/1ns
`include "serdes_defs.svh"

module word_deserializer import serdes_pkg::*; (
    input  logic  CLK,
    input  logic  rst,
    input  logic  line_bit,
    output word_t data_out,
    output logic  rdy
);

    localparam word_t TRAIN_WORD = {1'b1, {(`SER_WIDTH - 1){1'b0}}};

    des_state_t state;
    word_t      asm_word;     // last SER_WIDTH line bits, newest in lsb
    bit_cnt_t   bit_cnt;
    word_cnt_t  match_cnt;    // consecutive training hits
    logic       slip;         // stretches the next period by one cycle
    logic       boundary;
    logic       train_match;

    assign boundary    = (bit_cnt == bit_cnt_t'(`SER_WIDTH - 1));
    assign train_match = (asm_word == TRAIN_WORD);
    assign rdy         = (state == DES_LOCKED);

    ////////////////////////////////////////////////////////////
    // word assembly

    // free running, fills from the idle line during reset
    always_ff @(posedge CLK) begin
        asm_word <= {asm_word[`SER_WIDTH-2:0], line_bit};
    end

    ////////////////////////////////////////////////////////////
    // boundary strobe and bit slip

    always_ff @(posedge CLK) begin
        if (rst) begin
            bit_cnt <= '0;
        end else if (boundary) begin
            bit_cnt <= '0;
        end else if (!slip) begin
            bit_cnt <= bit_cnt + 1'b1;
        end
        // else hold one cycle, boundary moves one bit later
    end

    always_ff @(posedge CLK) begin
        if (rst) begin
            slip <= 1'b0;
        end else begin
            slip <= boundary && state == DES_SEARCH && !train_match;
        end
    end

    ////////////////////////////////////////////////////////////
    // lock detection

    always_ff @(posedge CLK) begin
        if (rst) begin
            state     <= DES_SEARCH;
            match_cnt <= '0;
        end else if (boundary && state == DES_SEARCH) begin
            if (train_match) begin
                if (match_cnt == word_cnt_t'(`LOCK_COUNT - 1)) begin
                    state <= DES_LOCKED;   // stays here until reset
                end
                match_cnt <= match_cnt + 1'b1;
            end else begin
                match_cnt <= '0;   // run broken, start over
            end
        end
    end

    // word output, only once aligned
    always_ff @(posedge CLK) begin
        if (rst) begin
            data_out <= '0;
        end else if (boundary && state == DES_LOCKED) begin
            data_out <= asm_word;
        end
    end

    // lock is sticky
    a_rdy_sticky: assert property (
        @(posedge CLK) disable iff (rst)
        rdy |=> rdy
    ) else $error("rdy dropped without reset");

    // nothing leaks to the output before lock
    a_data_quiet: assert property (
        @(posedge CLK) disable iff (rst)
        !rdy |=> $stable(data_out)
    ) else $error("data_out changed before lock");

endmodule

// ==== rtl/serdes_loopback.sv ====
`timescale 1ns/1ns

module serdes_loopback import serdes_pkg::*; (
    input  logic       CLK,
    input  logic       rst,
    input  logic [7:0] sw,
    input  delay_t     delay_sel,
    output word_t      data_out,
    output logic       rdy,
    output logic       ser_bit
);

    logic line_bit;   // ser_bit after the skew line

    ////////////////////////////////////////////////////////////
    // transmit side

    word_serializer u_ser (
        .CLK     (CLK),
        .rst     (rst),
        .sw      (sw),
        .ser_bit (ser_bit)
    );

    ////////////////////////////////////////////////////////////
    // line model

    line_delay u_line (
        .CLK       (CLK),
        .rst       (rst),
        .delay_sel (delay_sel),
        .ser_bit   (ser_bit),
        .line_bit  (line_bit)
    );

    ////////////////////////////////////////////////////////////
    // receive side

    word_deserializer u_des (
        .CLK      (CLK),
        .rst      (rst),
        .line_bit (line_bit),
        .data_out (data_out),
        .rdy      (rdy)
    );

endmodule

// ==== tb/tb_serdes_loopback.sv ====
`timescale 1ns/1ns
`include "serdes_defs.svh"

module tb_serdes_loopback import serdes_pkg::*; ();

    localparam int W          = `SER_WIDTH;
    localparam int LOCK_BOUND = `TRAIN_WORDS * `SER_WIDTH + `MAX_DELAY;
    localparam int DATA_START = `TRAIN_WORDS * `SER_WIDTH;  // first switch period
    localparam int TIMEOUT    = 200;
    localparam logic [7:0] SW_MASK = 8'((1 << W) - 1);

    logic       CLK;
    logic       rst;
    logic [7:0] sw;
    delay_t     delay_sel;
    word_t      data_out;
    logic       rdy;
    logic       ser_bit;

    int          errors;
    int          passed;
    int          failed;
    int          since_reset;   // cycles since rst went low
    logic [31:0] lcg_state;

    serdes_loopback dut (
        .CLK       (CLK),
        .rst       (rst),
        .sw        (sw),
        .delay_sel (delay_sel),
        .data_out  (data_out),
        .rdy       (rdy),
        .ser_bit   (ser_bit)
    );

    always #20 CLK = ~CLK;   // 40 ns period

    always @(posedge CLK) begin
        if (rst) begin
            since_reset <= 0;
        end else begin
            since_reset <= since_reset + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic check_idle();
        if (rdy !== 1'b0) begin
            $display("mismatch rdy: got %h expected 0", rdy);
            errors++;
        end
        if (data_out !== '0) begin
            $display("mismatch data_out: got %h expected 0", data_out);
            errors++;
        end
    endtask

    // two reset cycles with the outputs checked in each
    task automatic apply_reset(input delay_t d);
        rst       = 1'b1;
        delay_sel = d;
        repeat (2) begin
            @(posedge CLK);
            #5;
            check_idle();
        end
        rst = 1'b0;
    endtask

    task automatic wait_lock(output bit ok);
        int cycles;
        cycles = 0;
        ok     = 1'b0;
        while (rdy !== 1'b1 && cycles < TIMEOUT) begin
            @(posedge CLK);
            #5;
            cycles++;
        end
        if (rdy !== 1'b1) begin
            $display("rdy did not rise within %0d cycles of reset release", TIMEOUT);
            errors++;
        end else begin
            ok = 1'b1;
            if (since_reset > LOCK_BOUND) begin
                $display("lock took %0d cycles, more than the bound of %0d",
                         since_reset, LOCK_BOUND);
                errors++;
            end
        end
    endtask

    // switch words only reach the line once training is over
    task automatic wait_data_phase();
        int cycles;
        cycles = 0;
        while (since_reset < DATA_START && cycles < TIMEOUT) begin
            @(posedge CLK);
            #5;
            cycles++;
        end
        if (since_reset < DATA_START) begin
            $display("training phase did not end within %0d cycles", TIMEOUT);
            errors++;
        end
    endtask

    task automatic send_and_check();
        logic [31:0] r;
        logic [7:0]  sw_val;
        logic [7:0]  expected;
        logic [7:0]  got;
        r        = lcg_next();
        sw_val   = r[23:16];
        expected = sw_val & SW_MASK;
        sw       = sw_val;
        repeat (5 * W + int'(delay_sel)) @(posedge CLK);
        #5;
        for (int k = 0; k <= W; k++) begin
            if (k > 0) begin
                @(posedge CLK);
                #5;
            end
            got = data_out;
            if (got !== expected) begin
                $display("mismatch data_out: got %h expected %h (sw %h, cycle %0d)",
                         got, expected, sw_val, k);
                errors++;
                break;
            end
        end
    endtask

    task automatic end_test(input string name, input int errors_before);
        if (errors == errors_before) begin
            passed++;
            $display("%s: ok", name);
        end else begin
            failed++;
            $display("%s: fail, %0d errors", name, errors - errors_before);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // tests

    task automatic reset_state();
        int  start;
        logic exp_bit;
        start = errors;
        apply_reset(4'd0);
        for (int k = 0; k < W; k++) begin
            if (k > 0) begin
                @(posedge CLK);
                #5;
            end
            exp_bit = (k == 0);   // training word is a single one at the msb
            if (ser_bit !== exp_bit) begin
                $display("mismatch ser_bit: got %h expected %h (bit %0d)", ser_bit, exp_bit, k);
                errors++;
            end
            check_idle();
        end
        end_test("reset_state", start);
    endtask

    task automatic lock_at_zero_delay();
        int start;
        bit ok;
        start = errors;
        apply_reset(4'd0);
        wait_lock(ok);
        if (ok) begin
            for (int k = 0; k < 20 * W; k++) begin
                @(posedge CLK);
                #5;
                if (rdy !== 1'b1) begin
                    $display("mismatch rdy: got %h expected 1 (cycle %0d after lock)", rdy, k);
                    errors++;
                    break;
                end
            end
        end
        end_test("lock_at_zero_delay", start);
    endtask

    task automatic data_transfer();
        int start;
        start = errors;
        wait_data_phase();
        repeat (8) send_and_check();
        end_test("data_transfer", start);
    endtask

    task automatic every_delay();
        int start;
        bit ok;
        start = errors;
        for (int d = 0; d <= `MAX_DELAY; d++) begin
            apply_reset(delay_t'(d));
            wait_lock(ok);
            if (ok) begin
                wait_data_phase();
                repeat (2) send_and_check();
            end
        end
        end_test("every_delay", start);
    endtask

    task automatic relock_after_reset();
        int start;
        bit ok;
        start = errors;
        repeat (3) @(posedge CLK);   // land inside a word
        #5;
        apply_reset(4'd6);
        @(posedge CLK);   // first cycle out of reset
        #5;
        check_idle();
        wait_lock(ok);
        if (ok) begin
            wait_data_phase();
            repeat (2) send_and_check();
        end
        end_test("relock_after_reset", start);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence

    initial begin
        CLK       = 1'b0;
        rst       = 1'b1;
        sw        = 8'h00;
        delay_sel = 4'd0;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        lcg_state = 32'hce931c3c;

        reset_state();
        lock_at_zero_delay();
        data_transfer();
        every_delay();
        relock_after_reset();

        $display("tests passed %0d, failed %0d, errors %0d", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+include
rtl/serdes_pkg.sv
rtl/word_serializer.sv
rtl/line_delay.sv
rtl/word_deserializer.sv
rtl/serdes_loopback.sv
tb/tb_serdes_loopback.sv
